// ==== include/kcpu_settings.svh ====
// ---------------------------------------------------------------------------
// Global sizes for the execution unit of the 8/16-bit accumulator core.
// Included by the package and by any module that needs a raw width.
// ---------------------------------------------------------------------------
`ifndef KCPU_SETTINGS_SVH
`define KCPU_SETTINGS_SVH

// Data word and byte widths
`define KCPU_DW 16
`define KCPU_BW 8

// One divider iteration per dividend bit
`define KCPU_DIV_STEPS 16

`endif

// ==== src/kcpu_pkg.sv ====
// ---------------------------------------------------------------------------
// Shared types of the execution unit: operand widths, condition-code bit
// positions, operation codes, request and response structs and the
// controller states. Modules import it with a wildcard in their header.
// ---------------------------------------------------------------------------
`include "kcpu_settings.svh"

package kcpu_pkg;

    typedef logic [`KCPU_DW-1:0] word_t;   // Operand or result word
    typedef logic [`KCPU_BW-1:0] byte_t;   // Divisor, quotient, remainder
    typedef logic [7:0]          cc_t;     // Condition-code byte
    typedef logic [7:0]          op_t;     // Operation code
    typedef logic [$clog2(`KCPU_DIV_STEPS+1)-1:0] step_t;

    // Condition-code bit positions
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;
    localparam int CC_I = 4;
    localparam int CC_H = 5;
    localparam int CC_F = 6;
    localparam int CC_E = 7;

    // Byte operations sit at 0x00..0x14
    localparam op_t
        OP_LD8  = 8'h00, OP_ADD8 = 8'h01, OP_ADC8 = 8'h02,
        OP_SUB8 = 8'h03, OP_SBC8 = 8'h04, OP_AND8 = 8'h05,
        OP_EOR8 = 8'h06, OP_OR8  = 8'h07, OP_CLR8 = 8'h08,
        OP_COM8 = 8'h09, OP_NEG8 = 8'h0a, OP_INC8 = 8'h0b,
        OP_DEC8 = 8'h0c, OP_LSR8 = 8'h0d, OP_ROR8 = 8'h0e,
        OP_ASR8 = 8'h0f, OP_ASL8 = 8'h10, OP_ROL8 = 8'h11,
        OP_ABS8 = 8'h12, OP_DAA  = 8'h13, OP_SEX  = 8'h14;

    // Word operations all have bit 5 set, which the ALU uses as width decode
    localparam op_t
        OP_LD16  = 8'h20, OP_ADD16 = 8'h21, OP_SUB16 = 8'h22,
        OP_CMP16 = 8'h23, OP_NEG16 = 8'h24, OP_INC16 = 8'h25,
        OP_DEC16 = 8'h26, OP_LSR16 = 8'h27, OP_ROR16 = 8'h28,
        OP_ASR16 = 8'h29, OP_ASL16 = 8'h2a, OP_ROL16 = 8'h2b,
        OP_ABS16 = 8'h2c, OP_CLR16 = 8'h2d;

    // Flag, multiply and divide operations
    localparam op_t
        OP_ANDCC = 8'h40, OP_ORCC = 8'h41, OP_MUL  = 8'h42,
        OP_LMUL  = 8'h43, OP_DIVU = 8'h44, OP_DIVS = 8'h45;

    typedef struct packed {
        op_t   op;
        word_t opnd0;      // Accumulator side
        word_t opnd1;      // Memory or immediate side
        cc_t   cc;         // Incoming condition codes
    } exec_req_t;

    typedef struct packed {
        word_t rslt;
        word_t rslt_hi;    // Upper product word, LMUL only
        cc_t   cc;
    } exec_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DIV,
        ST_FIX
    } exec_state_t;

endpackage

// ==== src/kcpu_alu.sv ====
// ---------------------------------------------------------------------------
// Combinational ALU for every single-cycle operation of the core.
// Byte operations return their result zero-extended in rslt. Flags that
// an operation does not touch pass straight through from the request.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_alu import kcpu_pkg::*; (
    input  exec_req_t req,
    output exec_rsp_t rsp
);

    byte_t a8, b8, r8, corr;
    word_t a16, b16, r16, hi;
    cc_t   f;
    logic  cin, wide, zn_upd;
    logic [`KCPU_BW:0] s9;

    assign a8  = req.opnd0[`KCPU_BW-1:0];
    assign b8  = req.opnd1[`KCPU_BW-1:0];
    assign a16 = req.opnd0;
    assign b16 = req.opnd1;
    assign cin = req.cc[CC_C];

    // Word group, plus the other ops that produce a word
    assign wide = req.op[5] | (req.op == OP_SEX) | (req.op == OP_MUL)
                | (req.op == OP_LMUL);

    always_comb begin
        f      = req.cc;
        r8     = '0;
        r16    = '0;
        hi     = '0;
        corr   = '0;
        s9     = '0;
        zn_upd = 1'b1;
        case (req.op)
            OP_LD8:  begin r8  = b8;  f[CC_V] = 1'b0; end
            OP_LD16: begin r16 = b16; f[CC_V] = 1'b0; end
            OP_ADD8, OP_ADC8: begin
                {f[CC_C], r8} = {1'b0, a8} + {1'b0, b8}
                              + {8'd0, cin & (req.op == OP_ADC8)};
                f[CC_V] = (a8[7] == b8[7]) && (r8[7] != a8[7]);
                f[CC_H] = a8[4] ^ b8[4] ^ r8[4];  // Nibble carry
            end
            OP_ADD16: begin
                {f[CC_C], r16} = {1'b0, a16} + {1'b0, b16};
                f[CC_V] = (a16[15] == b16[15]) && (r16[15] != a16[15]);
            end
            OP_SUB8, OP_SBC8: begin
                {f[CC_C], r8} = {1'b0, a8} - {1'b0, b8}
                              - {8'd0, cin & (req.op == OP_SBC8)};
                f[CC_V] = (a8[7] != b8[7]) && (r8[7] != a8[7]);
            end
            OP_SUB16, OP_CMP16: begin
                {f[CC_C], r16} = {1'b0, a16} - {1'b0, b16};  // C is the borrow
                f[CC_V] = (a16[15] != b16[15]) && (r16[15] != a16[15]);
            end
            OP_AND8: begin r8 = a8 & b8; f[CC_V] = 1'b0; end
            OP_EOR8: begin r8 = a8 ^ b8; f[CC_V] = 1'b0; end
            OP_OR8:  begin r8 = a8 | b8; f[CC_V] = 1'b0; end
            OP_CLR8, OP_CLR16: begin
                f[CC_C] = 1'b0;
                f[CC_V] = 1'b0;
            end
            OP_COM8: begin
                r8      = ~a8;
                f[CC_C] = 1'b1;
                f[CC_V] = 1'b0;
            end
            OP_NEG8: begin
                {f[CC_C], r8} = 9'd0 - {1'b0, a8};
                f[CC_V] = a8 == 8'h80;           // -128 has no positive twin
            end
            OP_NEG16: begin
                {f[CC_C], r16} = 17'd0 - {1'b0, a16};
                f[CC_V] = a16 == 16'h8000;
            end
            OP_INC8:  begin r8  = a8 + 8'd1;   f[CC_V] = a8 == 8'h7f;     end
            OP_INC16: begin r16 = a16 + 16'd1; f[CC_V] = a16 == 16'h7fff; end
            OP_DEC8:  begin r8  = a8 - 8'd1;   f[CC_V] = a8 == 8'h80;     end
            OP_DEC16: begin r16 = a16 - 16'd1; f[CC_V] = a16 == 16'h8000; end
            OP_LSR8:  {r8, f[CC_C]}  = {1'b0, a8};
            OP_LSR16: {r16, f[CC_C]} = {1'b0, a16};
            OP_ROR8:  {r8, f[CC_C]}  = {cin, a8};
            OP_ROR16: {r16, f[CC_C]} = {cin, a16};
            OP_ASR8:  {r8, f[CC_C]}  = {a8[7], a8};
            OP_ASR16: {r16, f[CC_C]} = {a16[15], a16};
            OP_ASL8, OP_ROL8: begin
                {f[CC_C], r8} = {a8, cin & (req.op == OP_ROL8)};
                f[CC_V] = a8[7] ^ a8[6];
            end
            OP_ASL16, OP_ROL16: begin
                {f[CC_C], r16} = {a16, cin & (req.op == OP_ROL16)};
                f[CC_V] = a16[15] ^ a16[14];
            end
            OP_ABS8: begin
                r8      = a8[7] ? -a8 : a8;
                f[CC_C] = 1'b0;
                f[CC_V] = 1'b0;
                zn_upd  = 1'b0;
            end
            OP_ABS16: begin
                r16     = a16[15] ? -a16 : a16;
                f[CC_C] = 1'b0;
                f[CC_V] = 1'b0;
                zn_upd  = 1'b0;
            end
            OP_DAA: begin
                if (cin || a8[7:4] > 4'h9 || (a8[7:4] > 4'h8 && a8[3:0] > 4'h9))
                    corr[7:4] = 4'h6;
                if (req.cc[CC_H] || a8[3:0] > 4'h9)
                    corr[3:0] = 4'h6;
                s9      = {1'b0, a8} + {1'b0, corr};
                r8      = s9[7:0];
                f[CC_C] = cin | s9[8];           // Decimal carry is sticky
            end
            OP_SEX: begin
                r16     = {{8{a8[7]}}, a8};
                f[CC_V] = 1'b0;
            end
            OP_ANDCC: begin f = req.cc & b8; zn_upd = 1'b0; end
            OP_ORCC:  begin f = req.cc | b8; zn_upd = 1'b0; end
            OP_MUL: begin
                r16     = a16[15:8] * a16[7:0];
                f[CC_C] = r16[7];                // Rounding hint for the fraction
            end
            OP_LMUL: begin
                {hi, r16} = a16 * b16;
                f[CC_C]   = hi[15];
            end
            default: zn_upd = 1'b0;              // Divide is done elsewhere
        endcase

        if (zn_upd) begin
            f[CC_Z] = wide ? (r16 == '0) : (r8 == '0);
            f[CC_N] = wide ? r16[15] : r8[7];
        end
        if (req.op == OP_LMUL) begin             // Whole 32-bit product
            f[CC_Z] = {hi, r16} == '0;
            f[CC_N] = hi[15];
        end

        rsp.rslt    = wide ? r16 : word_t'(r8);
        rsp.rslt_hi = hi;
        rsp.cc      = f;
    end

endmodule

// ==== src/kcpu_div.sv ====
// ---------------------------------------------------------------------------
// Restoring shift-subtract divider, 16-bit dividend by 8-bit divisor.
// start loads the operand magnitudes, each step_en retires one quotient
// bit, and the signed results and overflow flag are presented once the
// last step is done.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_div import kcpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  cen,
    input  logic  start,
    input  logic  step_en,
    input  logic  sign,       // DIVS when set
    input  word_t dividend,
    input  byte_t divisor,
    output byte_t quot,
    output byte_t rem,
    output logic  v
);

    word_t dvd_mag, quo_r;
    byte_t dvs_mag, dvs_r, rem_r;
    logic  sign_r, neg_q, neg_r, dz, ovf;
    logic [`KCPU_BW+1:0] trial;

    assign dvd_mag = (sign && dividend[`KCPU_DW-1]) ? -dividend : dividend;
    assign dvs_mag = (sign && divisor[`KCPU_BW-1])  ? -divisor  : divisor;

    // Partial remainder shifted left with the next dividend bit, less divisor
    assign trial = {1'b0, rem_r, quo_r[`KCPU_DW-1]} - {2'b00, dvs_r};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sign_r <= 1'b0;
            neg_q  <= 1'b0;
            neg_r  <= 1'b0;
            dz     <= 1'b0;
        end else if (cen && start) begin
            sign_r <= sign;
            neg_q  <= sign && (dividend[`KCPU_DW-1] ^ divisor[`KCPU_BW-1]);
            neg_r  <= sign && dividend[`KCPU_DW-1];  // Remainder follows dividend
            dz     <= divisor == '0;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (start) begin
                quo_r <= dvd_mag;
                rem_r <= '0;
                dvs_r <= dvs_mag;
            end else if (step_en) begin
                if (!trial[`KCPU_BW+1]) begin      // Subtraction fits
                    rem_r <= trial[`KCPU_BW-1:0];
                    quo_r <= {quo_r[`KCPU_DW-2:0], 1'b1};
                end else begin
                    rem_r <= {rem_r[`KCPU_BW-2:0], quo_r[`KCPU_DW-1]};
                    quo_r <= {quo_r[`KCPU_DW-2:0], 1'b0};
                end
            end
        end
    end

    // Signed range is -128..127, unsigned range is 0..255
    assign ovf = sign_r ? (quo_r > (neg_q ? 16'd128 : 16'd127))
                        : (quo_r[`KCPU_DW-1:`KCPU_BW] != '0);
    assign v   = dz | ovf;

    assign quot = v ? '0 : (neg_q ? -quo_r[`KCPU_BW-1:0] : quo_r[`KCPU_BW-1:0]);
    assign rem  = v ? '0 : (neg_r ? -rem_r : rem_r);

endmodule

// ==== src/kcpu_step_count.sv ====
// ---------------------------------------------------------------------------
// Down-counter that paces the divider. load sets it to the step count,
// step_en stays high while the count is non-zero and last_step marks the
// final step.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_step_count import kcpu_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic cen,
    input  logic load,
    output logic step_en,
    output logic last_step
);

    step_t cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (cen) begin
            if (load)
                cnt <= step_t'(`KCPU_DIV_STEPS);
            else if (cnt != '0)
                cnt <= cnt - 1'b1;
        end
    end

    assign step_en   = cnt != '0;
    assign last_step = cnt == step_t'(1);

endmodule

// ==== src/kcpu_exec_ctrl.sv ====
// ---------------------------------------------------------------------------
// Controller of the execution unit. Captures one request per start pulse,
// returns ALU results one cycle later, or runs the divider and waits for
// its last step plus one fix-up cycle. rsp holds until the next done.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_exec_ctrl import kcpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      cen,
    input  logic      start,
    input  exec_req_t req,
    input  exec_rsp_t alu_rsp,
    input  logic      last_step,
    input  byte_t     quot,
    input  byte_t     rem,
    input  logic      div_v,
    output exec_req_t cur,
    output logic      div_start,
    output logic      div_sign,
    output logic      busy,
    output logic      done,
    output exec_rsp_t rsp
);

    exec_state_t state;
    exec_rsp_t   div_rsp;
    logic        alu_pend;   // ALU result due on the next edge
    logic        accept;
    logic        req_div;

    assign req_div  = (req.op == OP_DIVU) || (req.op == OP_DIVS);
    assign accept   = start && (state == ST_IDLE) && !alu_pend;
    assign busy     = state != ST_IDLE;
    assign div_sign = cur.op == OP_DIVS;

    // Held request feeds the ALU and the divider operands
    always_ff @(posedge clk) begin
        if (cen && accept)
            cur <= req;
    end

    always_comb begin
        div_rsp         = '0;
        div_rsp.rslt    = {rem, quot};
        div_rsp.cc      = cur.cc;
        div_rsp.cc[CC_C] = 1'b0;
        div_rsp.cc[CC_V] = div_v;
        div_rsp.cc[CC_Z] = quot == '0;
        div_rsp.cc[CC_N] = quot[`KCPU_BW-1];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            alu_pend  <= 1'b0;
            div_start <= 1'b0;
            done      <= 1'b0;
            rsp       <= '0;
        end else if (cen) begin
            div_start <= 1'b0;
            done      <= 1'b0;
            alu_pend  <= 1'b0;
            if (alu_pend) begin
                rsp  <= alu_rsp;
                done <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (accept && req_div) begin
                        state     <= ST_DIV;
                        div_start <= 1'b1;
                    end else if (accept) begin
                        alu_pend  <= 1'b1;
                    end
                end
                ST_DIV: if (last_step) state <= ST_FIX;
                ST_FIX: begin                    // Divider outputs now settled
                    rsp   <= div_rsp;
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== src/kcpu_exec.sv ====
// ---------------------------------------------------------------------------
// Top level of the execution unit. Pulse start with req, then wait for
// done. Divides keep busy high while they run and cen low freezes the
// whole unit.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_exec import kcpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      cen,
    input  logic      start,
    input  exec_req_t req,
    output logic      busy,
    output logic      done,
    output exec_rsp_t rsp
);

    exec_req_t cur;
    exec_rsp_t alu_rsp;
    logic      div_start, div_sign, div_v;
    logic      step_en, last_step;
    byte_t     quot, rem;

    kcpu_exec_ctrl u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .cen       (cen),
        .start     (start),
        .req       (req),
        .alu_rsp   (alu_rsp),
        .last_step (last_step),
        .quot      (quot),
        .rem       (rem),
        .div_v     (div_v),
        .cur       (cur),
        .div_start (div_start),
        .div_sign  (div_sign),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp)
    );

    kcpu_alu u_alu (
        .req (cur),
        .rsp (alu_rsp)
    );

    kcpu_div u_div (
        .clk      (clk),
        .arst_n   (arst_n),
        .cen      (cen),
        .start    (div_start),
        .step_en  (step_en),
        .sign     (div_sign),
        .dividend (cur.opnd0),
        .divisor  (cur.opnd1[`KCPU_BW-1:0]),
        .quot     (quot),
        .rem      (rem),
        .v        (div_v)
    );

    kcpu_step_count u_steps (
        .clk       (clk),
        .arst_n    (arst_n),
        .cen       (cen),
        .load      (div_start),
        .step_en   (step_en),
        .last_step (last_step)
    );

endmodule

// ==== tb/kcpu_exec_assert.sv ====
// ---------------------------------------------------------------------------
// Handshake checks for the execution unit, bound to the top level.
// Watches done, busy and start at every rising clock edge.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module kcpu_exec_assert (
    input logic clk,
    input logic arst_n,
    input logic cen,
    input logic start,
    input logic busy,
    input logic done
);

    // done is a one-cycle strobe while the unit is enabled
    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        (done && cen) |=> !done)
        else $error("done stayed high for more than one cycle");

    a_busy_done: assert property (@(posedge clk) disable iff (!arst_n)
        !(busy && done))
        else $error("busy and done high at the same time");

    // ALU results follow start by two samples, divides end a busy phase
    a_done_cause: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> ($past(busy) || $past(start, 2)))
        else $error("done without a preceding start");

    a_reset_idle: assert property (@(posedge clk)
        $rose(arst_n) |-> (!done && !busy))
        else $error("done or busy high right after reset");

endmodule

bind kcpu_exec kcpu_exec_assert u_assert (
    .clk    (clk),
    .arst_n (arst_n),
    .cen    (cen),
    .start  (start),
    .busy   (busy),
    .done   (done)
);

// ==== tb/kcpu_exec_tb.sv ====
// ---------------------------------------------------------------------------
// Directed testbench of the execution unit. Each test task issues requests
// on the falling clock edge, waits for done and compares rsp and the
// latency with reference models of the ALU and divider rules.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module kcpu_exec_tb import kcpu_pkg::*;;

    localparam int MAX_CYCLES = 4000;    // Tests need about 2100 cycles

    logic      clk = 1'b0;
    logic      arst_n = 1'b0;
    logic      cen = 1'b1;
    logic      start = 1'b0;
    exec_req_t req = '0;
    logic      busy, done;
    exec_rsp_t rsp;

    int          value_errors = 0;
    int          proto_errors = 0;
    int          cycles = 0;
    logic [31:0] rng_state = 32'd10152;
    word_t       edge_vals [8] = '{16'h0000, 16'h0001, 16'h007f, 16'h0080,
                                   16'h00ff, 16'h7fff, 16'h8000, 16'hffff};

    kcpu_exec UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .cen    (cen),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .rsp    (rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles before the tests ended", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    function automatic exec_req_t make_req(op_t op, word_t a, word_t b, cc_t cc);
        exec_req_t q;
        q.op    = op;
        q.opnd0 = a;
        q.opnd1 = b;
        q.cc    = cc;
        return q;
    endfunction

    // Single-cycle operations, computed over the operation width n
    function automatic exec_rsp_t alu_model(exec_req_t q);
        exec_rsp_t   p;
        cc_t         f;
        int          n, lo, hi, corr;
        logic [31:0] a, b, r, m, top;
        logic        c, cin, zn;
        p    = '0;
        f    = q.cc;
        c    = q.cc[CC_C];
        cin  = (q.op == OP_ADC8 || q.op == OP_SBC8) ? c : 1'b0;
        zn   = 1'b1;
        n    = ((q.op >= OP_LD16 && q.op <= OP_CLR16) ||
                q.op inside {OP_SEX, OP_MUL, OP_LMUL}) ? 16 : 8;
        m    = (32'd1 << n) - 1;
        top  = 32'd1 << (n - 1);
        a    = q.opnd0 & m;
        b    = q.opnd1 & m;
        r    = '0;
        case (q.op)
            OP_LD8, OP_LD16: begin r = b; f[CC_V] = 1'b0; end
            OP_ADD8, OP_ADC8, OP_ADD16: begin
                r       = a + b + cin;
                f[CC_C] = r[n];
                f[CC_V] = (a[n-1] == b[n-1]) && (r[n-1] != a[n-1]);
                if (n == 8)
                    f[CC_H] = (a % 16 + b % 16 + cin) > 15;
            end
            OP_SUB8, OP_SBC8, OP_SUB16, OP_CMP16: begin
                r       = a - b - cin;
                f[CC_C] = a < b + cin;                   // Borrow
                f[CC_V] = (a[n-1] != b[n-1]) && (r[n-1] != a[n-1]);
            end
            OP_AND8: begin r = a & b; f[CC_V] = 1'b0; end
            OP_EOR8: begin r = a ^ b; f[CC_V] = 1'b0; end
            OP_OR8:  begin r = a | b; f[CC_V] = 1'b0; end
            OP_CLR8, OP_CLR16: begin f[CC_C] = 1'b0; f[CC_V] = 1'b0; end
            OP_COM8: begin r = ~a; f[CC_C] = 1'b1; f[CC_V] = 1'b0; end
            OP_NEG8, OP_NEG16: begin
                r       = 32'd0 - a;
                f[CC_C] = a != 0;
                f[CC_V] = a == top;
            end
            OP_INC8, OP_INC16: begin r = a + 1; f[CC_V] = a == top - 1; end
            OP_DEC8, OP_DEC16: begin r = a - 1; f[CC_V] = a == top; end
            OP_LSR8, OP_LSR16: begin r = a >> 1; f[CC_C] = a[0]; end
            OP_ROR8, OP_ROR16: begin r = (a >> 1) | (c ? top : 32'd0); f[CC_C] = a[0]; end
            OP_ASR8, OP_ASR16: begin r = (a >> 1) | (a & top); f[CC_C] = a[0]; end
            OP_ASL8, OP_ROL8, OP_ASL16, OP_ROL16: begin
                r       = (a << 1) | {31'd0, c && (q.op == OP_ROL8 || q.op == OP_ROL16)};
                f[CC_C] = a[n-1];
                f[CC_V] = a[n-1] ^ a[n-2];
            end
            OP_ABS8, OP_ABS16: begin
                r       = a[n-1] ? 32'd0 - a : a;
                f[CC_C] = 1'b0;
                f[CC_V] = 1'b0;
                zn      = 1'b0;
            end
            OP_DAA: begin
                lo   = int'(a[3:0]);
                hi   = int'(a[7:4]);
                corr = 0;
                if (q.cc[CC_H] || lo > 9)
                    corr = corr + 6;
                if (c || hi > 9 || (hi > 8 && lo > 9))
                    corr = corr + 96;
                r       = a + corr;
                f[CC_C] = c | r[8];
            end
            OP_SEX: begin r = {{24{q.opnd0[7]}}, q.opnd0[7:0]}; f[CC_V] = 1'b0; end
            OP_ANDCC: begin f = q.cc & q.opnd1[7:0]; zn = 1'b0; end
            OP_ORCC:  begin f = q.cc | q.opnd1[7:0]; zn = 1'b0; end
            OP_MUL: begin r = q.opnd0[15:8] * q.opnd0[7:0]; f[CC_C] = r[7]; end
            OP_LMUL: begin
                r         = a * b;
                p.rslt_hi = r[31:16];
                f[CC_C]   = r[31];
                f[CC_Z]   = r == 0;
                f[CC_N]   = r[31];
                zn        = 1'b0;
            end
            default: zn = 1'b0;
        endcase
        if (zn) begin
            f[CC_Z] = (r & m) == 0;
            f[CC_N] = r[n-1];
        end
        p.rslt = word_t'(r & m);
        p.cc   = f;
        return p;
    endfunction

    function automatic exec_rsp_t div_model(exec_req_t q);
        exec_rsp_t p;
        int        x, y, qt, rm;
        logic      sgn, neg_q, neg_r, v;
        byte_t     qb, rb;
        sgn   = q.op == OP_DIVS;
        x     = sgn ? int'($signed(q.opnd0)) : int'(q.opnd0);
        y     = sgn ? int'($signed(q.opnd1[7:0])) : int'(q.opnd1[7:0]);
        neg_q = sgn && ((x < 0) != (y < 0));
        neg_r = sgn && (x < 0);                          // Remainder sign of dividend
        x     = (x < 0) ? -x : x;
        y     = (y < 0) ? -y : y;
        qt    = 0;
        rm    = 0;
        v     = y == 0;
        if (!v) begin
            qt = x / y;
            rm = x % y;
            v  = sgn ? (qt > (neg_q ? 128 : 127)) : (qt > 255);
        end
        qb         = v ? 8'h00 : byte_t'(neg_q ? -qt : qt);
        rb         = v ? 8'h00 : byte_t'(neg_r ? -rm : rm);
        p          = '0;
        p.rslt     = {rb, qb};
        p.cc       = q.cc;
        p.cc[CC_C] = 1'b0;
        p.cc[CC_V] = v;
        p.cc[CC_Z] = qb == 0;
        p.cc[CC_N] = qb[7];
        return p;
    endfunction

    task automatic log_value_error(input string name, input exec_req_t q,
                                   input word_t got, input word_t want);
        value_errors++;
        $display("mismatch %s: got %h expected %h (op %h opnd0 %h opnd1 %h cc %h)",
                 name, got, want, q.op, q.opnd0, q.opnd1, q.cc);
    endtask

    task automatic log_protocol_error(input string what);
        proto_errors++;
        $display("protocol error: %s", what);
    endtask

    // Issue one request, optionally stall cen or poke start while it runs
    task automatic run_op(input exec_req_t q, input int stall_at, input int stall_len,
                          input bit poke);
        exec_rsp_t exp;
        bit        is_div;
        int        lat;
        int        lat_exp;
        is_div  = (q.op == OP_DIVU) || (q.op == OP_DIVS);
        exp     = is_div ? div_model(q) : alu_model(q);
        lat_exp = (is_div ? 18 : 1) + stall_len;
        req     = q;
        start   = 1'b1;
        @(negedge clk);                                  // Request taken
        start = 1'b0;
        lat   = 0;
        while (!done && lat < 40) begin
            assert (busy == is_div) else log_protocol_error("busy wrong while waiting");
            @(negedge clk);
            lat++;
            if (poke && lat == 3) begin
                start = 1'b1;
                req   = make_req(OP_DIVU, 16'h00ff, 16'h0001, 8'h00);
            end else begin
                start = 1'b0;
            end
            cen = !(lat >= stall_at && lat < stall_at + stall_len);
        end
        assert (done) else log_protocol_error("done never arrived");
        assert (lat == lat_exp)
            else begin
                proto_errors++;
                $display("mismatch latency of op %h: got %h expected %h", q.op, lat, lat_exp);
            end
        if (done) begin
            assert (rsp.rslt == exp.rslt) else log_value_error("rsp.rslt", q, rsp.rslt, exp.rslt);
            assert (rsp.rslt_hi == exp.rslt_hi)
                else log_value_error("rsp.rslt_hi", q, rsp.rslt_hi, exp.rslt_hi);
            assert (rsp.cc == exp.cc) else log_value_error("rsp.cc", q, rsp.cc, exp.cc);
        end
    endtask

    // Boundary operands for k below 8, random ones after that
    task automatic run_mixed(input op_t op, input int k);
        logic [31:0] rnd;
        word_t       a, b;
        rnd = next_random();
        a   = (k < 8) ? edge_vals[k] : rnd[15:0];
        b   = (k < 8) ? edge_vals[(k * 3 + 5) % 8] : rnd[31:16];
        run_op(make_req(op, a, b, cc_t'(next_random())), 0, 0, 1'b0);
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (!done && !busy) else log_protocol_error("done or busy with nothing running");
        end
    endtask

    task automatic test_arith();
        op_t ops [18] = '{OP_LD8, OP_ADD8, OP_ADC8, OP_SUB8, OP_SBC8, OP_NEG8, OP_INC8,
                          OP_DEC8, OP_ABS8, OP_DAA, OP_LD16, OP_ADD16, OP_SUB16, OP_CMP16,
                          OP_NEG16, OP_INC16, OP_DEC16, OP_ABS16};
        foreach (ops[i])
            for (int k = 0; k < 16; k++)
                run_mixed(ops[i], k);
    endtask

    task automatic test_logic();
        op_t ops [19] = '{OP_AND8, OP_EOR8, OP_OR8, OP_COM8, OP_CLR8, OP_LSR8, OP_ROR8,
                          OP_ASR8, OP_ASL8, OP_ROL8, OP_SEX, OP_CLR16, OP_LSR16, OP_ROR16,
                          OP_ASR16, OP_ASL16, OP_ROL16, OP_ANDCC, OP_ORCC};
        foreach (ops[i])
            for (int k = 0; k < 12; k++)
                run_mixed(ops[i], k);
    endtask

    task automatic test_mul();
        for (int k = 0; k < 20; k++) begin
            run_mixed(OP_MUL, k);
            run_mixed(OP_LMUL, k);
        end
    endtask

    task automatic test_div();
        logic [31:0] rnd;
        word_t       dvd;
        run_op(make_req(OP_DIVU, 16'h1234, 16'h0000, 8'h00), 0, 0, 1'b0);
        run_op(make_req(OP_DIVU, 16'hffff, 16'h0001, 8'hff), 0, 0, 1'b0);
        run_op(make_req(OP_DIVU, 16'h00ff, 16'h0001, 8'h00), 0, 0, 1'b0);
        run_op(make_req(OP_DIVS, 16'hff80, 16'h0001, 8'h00), 0, 0, 1'b0);
        run_op(make_req(OP_DIVS, 16'h0080, 16'h0001, 8'h00), 0, 0, 1'b0);
        run_op(make_req(OP_DIVS, 16'h8000, 16'h00ff, 8'h00), 0, 0, 1'b0);
        run_op(make_req(OP_DIVS, 16'h0007, 16'h00fe, 8'h0f), 0, 0, 1'b0);
        run_op(make_req(OP_DIVS, 16'hfff9, 16'h0002, 8'hf0), 0, 0, 1'b0);
        for (int k = 0; k < 40; k++) begin
            rnd = next_random();
            dvd = rnd[15:0] >> rnd[19:16];           // Spread of quotient sizes
            if (rnd[20])
                dvd = -dvd;
            run_op(make_req(k[0] ? OP_DIVS : OP_DIVU, dvd,
                            (k % 8 == 7) ? 16'h0000 : {8'h00, rnd[31:24]},
                            cc_t'(next_random())), 0, 0, 1'b0);
        end
    endtask

    task automatic test_stall_and_ignore();
        run_op(make_req(OP_DIVU, 16'h053a, 16'h0007, 8'h0f), 0, 0, 1'b1);
        check_quiet(3);
        run_op(make_req(OP_DIVS, 16'hfc18, 16'h0009, 8'hf0), 6, 5, 1'b0);
        run_op(make_req(OP_DIVS, 16'h1000, 16'h00f3, 8'h00), 4, 3, 1'b1);
        check_quiet(6);
        run_op(make_req(OP_ADD8, 16'h0048, 16'h0039, 8'h00), 0, 0, 1'b0);
    endtask

    initial begin
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        assert (!done && !busy && rsp == '0) else log_protocol_error("outputs not idle after reset");
        test_arith();
        test_logic();
        test_mul();
        test_div();
        test_stall_and_ignore();
        repeat (2) @(negedge clk);
        $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
src/kcpu_pkg.sv
src/kcpu_alu.sv
src/kcpu_div.sv
src/kcpu_step_count.sv
src/kcpu_exec_ctrl.sv
src/kcpu_exec.sv
tb/kcpu_exec_assert.sv
tb/kcpu_exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and decide the outcome from sim.log
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module kcpu_exec_tb -o Vkcpu_exec_tb \
    && ./obj_dir/Vkcpu_exec_tb; } > sim.log 2>&1 || true
cat sim.log
grep -qx 'All tests passed!' sim.log && exit 0 || exit 1
